/* rtl/tomasulo_pkg.sv */
`default_nettype none

package tomasulo_pkg;

  localparam int XLEN = 32;
  localparam int TAG_W = 4;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [4:0] reg_id_t;

  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_id_t rs2;
    reg_id_t rs1;
    logic [2:0] funct3;
    reg_id_t rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_id_t rs1;
    logic [2:0] funct3;
    reg_id_t rd;
    logic [6:0] opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
  } rv_inst_u;

  // tag 0 means the value is already here
  typedef struct packed {
    logic pending;
    tag_t tag;
    word_t value;
  } operand_t;

  typedef struct packed {
    alu_op_t op;
    operand_t src1;
    operand_t src2;
    tag_t dest;
  } rs_payload_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
    word_t value;
  } cdb_t;

  function automatic word_t alu_compute(alu_op_t op, word_t a, word_t b);
    logic [4:0] shamt;
    word_t res;
    shamt = b[4:0];
    case (op)
      ALU_ADD: res = a + b;
      ALU_SUB: res = a - b;
      ALU_SLL: res = a << shamt;
      ALU_SLT: res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: res = {{(XLEN-1){1'b0}}, a < b};
      ALU_XOR: res = a ^ b;
      ALU_SRL: res = a >> shamt;
      ALU_SRA: res = word_t'($signed(a) >>> shamt);
      ALU_OR: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // pick up a broadcast value for a waiting operand
  function automatic operand_t operand_snoop(operand_t src, cdb_t bus);
    operand_t res;
    res = src;
    if (src.pending && bus.valid && bus.tag == src.tag) begin
      res.pending = 1'b0;
      res.tag = '0;
      res.value = bus.value;
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* rtl/reg_status_file.sv */
`default_nettype none

module reg_status_file (
  input wire clk_in,
  input wire rst_in,
  input wire tomasulo_pkg::reg_id_t rs1_id,
  input wire tomasulo_pkg::reg_id_t rs2_id,
  output tomasulo_pkg::operand_t rs1_op,
  output tomasulo_pkg::operand_t rs2_op,
  input wire rename_en,
  input wire tomasulo_pkg::reg_id_t rename_rd,
  input wire tomasulo_pkg::tag_t rename_tag,
  input wire tomasulo_pkg::cdb_t cdb,
  input wire tomasulo_pkg::reg_id_t dbg_reg_addr,
  output tomasulo_pkg::word_t dbg_reg_data
);

  // x0 has no storage
  tomasulo_pkg::word_t vals [1:31];
  tomasulo_pkg::tag_t tags [1:31];
  logic [31:1] cdb_hit;

  always_comb begin
    for (int i = 1; i < 32; i++) begin
      cdb_hit[i] = cdb.valid && tags[i] != '0 && tags[i] == cdb.tag;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 1; i < 32; i++) begin
        vals[i] <= '0;
        tags[i] <= '0;
      end
    end else begin
      for (int i = 1; i < 32; i++) begin
        if (cdb_hit[i]) begin
          vals[i] <= cdb.value;
        end
        // a new producer takes over the register
        if (rename_en && rename_rd == tomasulo_pkg::reg_id_t'(i)) begin
          tags[i] <= rename_tag;
        end else if (cdb_hit[i]) begin
          tags[i] <= '0;
        end
      end
    end
  end

  always_comb begin
    rs1_op = '0;
    rs2_op = '0;
    if (rs1_id != '0) begin
      rs1_op.pending = tags[rs1_id] != '0;
      rs1_op.tag = tags[rs1_id];
      rs1_op.value = vals[rs1_id];
    end
    if (rs2_id != '0) begin
      rs2_op.pending = tags[rs2_id] != '0;
      rs2_op.tag = tags[rs2_id];
      rs2_op.value = vals[rs2_id];
    end
  end

  assign dbg_reg_data = (dbg_reg_addr == '0) ? '0 : vals[dbg_reg_addr];

endmodule

`default_nettype wire

/* rtl/issue_unit.sv */
`default_nettype none

module issue_unit #(
  parameter int NUM_RS = 6
) (
  input wire clk_in,
  input wire rst_in,
  input wire inst_valid,
  input wire tomasulo_pkg::rv_inst_u inst,
  input wire [NUM_RS-1:0] busy,
  input wire tomasulo_pkg::cdb_t cdb,
  output tomasulo_pkg::reg_id_t rs1_id,
  output tomasulo_pkg::reg_id_t rs2_id,
  input wire tomasulo_pkg::operand_t rs1_op,
  input wire tomasulo_pkg::operand_t rs2_op,
  output logic rename_en,
  output tomasulo_pkg::reg_id_t rename_rd,
  output tomasulo_pkg::tag_t rename_tag,
  output logic [NUM_RS-1:0] alloc_onehot,
  output tomasulo_pkg::rs_payload_t payload,
  output logic full
);

  logic legal;
  logic is_imm;
  logic accept;
  logic full_q;
  tomasulo_pkg::alu_op_t op;
  tomasulo_pkg::word_t imm_ext;
  tomasulo_pkg::tag_t new_tag;
  logic [NUM_RS-1:0] free_onehot;

  // the shift forms of OP-IMM keep funct7 in the upper immediate bits
  always_comb begin
    legal = 1'b0;
    is_imm = 1'b0;
    op = tomasulo_pkg::ALU_ADD;
    if (inst.r_type.opcode == tomasulo_pkg::OPC_OP) begin
      legal = 1'b1;
      case ({inst.r_type.funct7, inst.r_type.funct3})
        {tomasulo_pkg::F7_BASE, tomasulo_pkg::F3_ADD}: op = tomasulo_pkg::ALU_ADD;
        {tomasulo_pkg::F7_ALT, tomasulo_pkg::F3_ADD}: op = tomasulo_pkg::ALU_SUB;
        {tomasulo_pkg::F7_BASE, tomasulo_pkg::F3_SLL}: op = tomasulo_pkg::ALU_SLL;
        {tomasulo_pkg::F7_BASE, tomasulo_pkg::F3_SLT}: op = tomasulo_pkg::ALU_SLT;
        {tomasulo_pkg::F7_BASE, tomasulo_pkg::F3_SLTU}: op = tomasulo_pkg::ALU_SLTU;
        {tomasulo_pkg::F7_BASE, tomasulo_pkg::F3_XOR}: op = tomasulo_pkg::ALU_XOR;
        {tomasulo_pkg::F7_BASE, tomasulo_pkg::F3_SRL}: op = tomasulo_pkg::ALU_SRL;
        {tomasulo_pkg::F7_ALT, tomasulo_pkg::F3_SRL}: op = tomasulo_pkg::ALU_SRA;
        {tomasulo_pkg::F7_BASE, tomasulo_pkg::F3_OR}: op = tomasulo_pkg::ALU_OR;
        {tomasulo_pkg::F7_BASE, tomasulo_pkg::F3_AND}: op = tomasulo_pkg::ALU_AND;
        default: legal = 1'b0;
      endcase
    end else if (inst.i_type.opcode == tomasulo_pkg::OPC_OP_IMM) begin
      legal = 1'b1;
      is_imm = 1'b1;
      case (inst.i_type.funct3)
        tomasulo_pkg::F3_ADD: op = tomasulo_pkg::ALU_ADD;
        tomasulo_pkg::F3_SLT: op = tomasulo_pkg::ALU_SLT;
        tomasulo_pkg::F3_SLTU: op = tomasulo_pkg::ALU_SLTU;
        tomasulo_pkg::F3_XOR: op = tomasulo_pkg::ALU_XOR;
        tomasulo_pkg::F3_OR: op = tomasulo_pkg::ALU_OR;
        tomasulo_pkg::F3_AND: op = tomasulo_pkg::ALU_AND;
        tomasulo_pkg::F3_SLL: begin
          op = tomasulo_pkg::ALU_SLL;
          legal = inst.r_type.funct7 == tomasulo_pkg::F7_BASE;
        end
        default: begin
          op = (inst.r_type.funct7 == tomasulo_pkg::F7_ALT) ?
               tomasulo_pkg::ALU_SRA : tomasulo_pkg::ALU_SRL;
          legal = inst.r_type.funct7 == tomasulo_pkg::F7_BASE ||
                  inst.r_type.funct7 == tomasulo_pkg::F7_ALT;
        end
      endcase
    end
  end

  assign imm_ext = {{(tomasulo_pkg::XLEN-12){inst.i_type.imm12[11]}}, inst.i_type.imm12};

  // lowest free station and its tag
  assign free_onehot = ~busy & (busy + 1'b1);

  always_comb begin
    new_tag = '0;
    for (int i = NUM_RS - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        new_tag = tomasulo_pkg::tag_t'(i + 1);
      end
    end
  end

  // full_q ignores the grant of the last edge, and a broadcast now means one was freed
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      full_q <= 1'b0;
    end else begin
      full_q <= &(busy | alloc_onehot);
    end
  end

  assign full = full_q & ~cdb.valid;
  assign accept = inst_valid & ~full & legal;
  assign alloc_onehot = accept ? free_onehot : '0;

  assign rs1_id = inst.r_type.rs1;
  assign rs2_id = inst.r_type.rs2;

  always_comb begin
    payload.op = op;
    payload.src1 = tomasulo_pkg::operand_snoop(rs1_op, cdb);
    if (is_imm) begin
      payload.src2 = '{pending: 1'b0, tag: '0, value: imm_ext};
    end else begin
      payload.src2 = tomasulo_pkg::operand_snoop(rs2_op, cdb);
    end
    payload.dest = new_tag;
  end

  assign rename_en = accept && inst.r_type.rd != '0;
  assign rename_rd = inst.r_type.rd;
  assign rename_tag = new_tag;

endmodule

`default_nettype wire

/* rtl/rs_entry.sv */
`default_nettype none

module rs_entry (
  input wire clk_in,
  input wire rst_in,
  input wire load,
  input wire tomasulo_pkg::rs_payload_t payload,
  input wire tomasulo_pkg::cdb_t cdb,
  input wire grant,
  output logic busy,
  output logic ready,
  output tomasulo_pkg::tag_t tag,
  output tomasulo_pkg::word_t result
);

  logic busy_q;
  tomasulo_pkg::rs_payload_t held;

  // load and grant never meet since a granted station is busy
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
    end else if (load) begin
      busy_q <= 1'b1;
    end else if (grant) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (load) begin
      held <= payload;
    end else begin
      held.src1 <= tomasulo_pkg::operand_snoop(held.src1, cdb);
      held.src2 <= tomasulo_pkg::operand_snoop(held.src2, cdb);
    end
  end

  assign busy = busy_q;
  assign ready = busy_q & ~held.src1.pending & ~held.src2.pending;
  assign tag = held.dest;
  assign result = tomasulo_pkg::alu_compute(held.op, held.src1.value, held.src2.value);

endmodule

`default_nettype wire

/* rtl/cdb_arbiter.sv */
`default_nettype none

module cdb_arbiter #(
  parameter int NUM_RS = 6
) (
  input wire clk_in,
  input wire rst_in,
  input wire [NUM_RS-1:0] ready,
  input wire tomasulo_pkg::tag_t tags [NUM_RS],
  input wire tomasulo_pkg::word_t results [NUM_RS],
  output logic [NUM_RS-1:0] grant,
  output tomasulo_pkg::cdb_t cdb
);

  logic valid_q;
  tomasulo_pkg::tag_t tag_q;
  tomasulo_pkg::word_t value_q;
  tomasulo_pkg::tag_t sel_tag;
  tomasulo_pkg::word_t sel_value;

  // lowest index wins
  assign grant = ready & (~ready + 1'b1);

  always_comb begin
    sel_tag = '0;
    sel_value = '0;
    for (int i = NUM_RS - 1; i >= 0; i--) begin
      if (ready[i]) begin
        sel_tag = tags[i];
        sel_value = results[i];
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= |ready;
    end
  end

  always_ff @(posedge clk_in) begin
    tag_q <= sel_tag;
    value_q <= sel_value;
  end

  assign cdb = '{valid: valid_q, tag: tag_q, value: value_q};

endmodule

`default_nettype wire

/* rtl/tomasulo_core.sv */
`default_nettype none

module tomasulo_core #(
  parameter int NUM_RS = 6
) (
  input wire clk_in,
  input wire rst_in,
  input wire inst_valid,
  input wire tomasulo_pkg::rv_inst_u inst,
  output logic full,
  output logic idle,
  output tomasulo_pkg::cdb_t cdb,
  input wire tomasulo_pkg::reg_id_t dbg_reg_addr,
  output tomasulo_pkg::word_t dbg_reg_data
);

  wire [NUM_RS-1:0] busy;
  wire [NUM_RS-1:0] ready;
  wire [NUM_RS-1:0] grant;
  wire [NUM_RS-1:0] alloc_onehot;
  wire tomasulo_pkg::tag_t tags [NUM_RS];
  wire tomasulo_pkg::word_t results [NUM_RS];
  wire tomasulo_pkg::rs_payload_t payload;
  wire tomasulo_pkg::reg_id_t rs1_id;
  wire tomasulo_pkg::reg_id_t rs2_id;
  wire tomasulo_pkg::operand_t rs1_op;
  wire tomasulo_pkg::operand_t rs2_op;
  wire rename_en;
  wire tomasulo_pkg::reg_id_t rename_rd;
  wire tomasulo_pkg::tag_t rename_tag;

  issue_unit #(
    .NUM_RS(NUM_RS)
  ) issue_unit_0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .inst_valid(inst_valid),
    .inst(inst),
    .busy(busy),
    .cdb(cdb),
    .rs1_id(rs1_id),
    .rs2_id(rs2_id),
    .rs1_op(rs1_op),
    .rs2_op(rs2_op),
    .rename_en(rename_en),
    .rename_rd(rename_rd),
    .rename_tag(rename_tag),
    .alloc_onehot(alloc_onehot),
    .payload(payload),
    .full(full)
  );

  reg_status_file reg_status_file_0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .rs1_id(rs1_id),
    .rs2_id(rs2_id),
    .rs1_op(rs1_op),
    .rs2_op(rs2_op),
    .rename_en(rename_en),
    .rename_rd(rename_rd),
    .rename_tag(rename_tag),
    .cdb(cdb),
    .dbg_reg_addr(dbg_reg_addr),
    .dbg_reg_data(dbg_reg_data)
  );

  for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
    rs_entry rs_entry_i (
      .clk_in(clk_in),
      .rst_in(rst_in),
      .load(alloc_onehot[i]),
      .payload(payload),
      .cdb(cdb),
      .grant(grant[i]),
      .busy(busy[i]),
      .ready(ready[i]),
      .tag(tags[i]),
      .result(results[i])
    );
  end

  cdb_arbiter #(
    .NUM_RS(NUM_RS)
  ) cdb_arbiter_0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .ready(ready),
    .tags(tags),
    .results(results),
    .grant(grant),
    .cdb(cdb)
  );

  // the register write of the last broadcast lands with idle
  assign idle = ~|busy & ~cdb.valid;

endmodule

`default_nettype wire

/* bench/tomasulo_core_properties.sv */
`default_nettype none

module tomasulo_core_properties (
  input wire clk_in,
  input wire rst_in,
  input wire tomasulo_pkg::cdb_t cdb,
  input wire full,
  input wire idle
);

  // tag 0 is reserved for values that need no producer
  a_cdb_tag_nonzero: assert property (
    @(posedge clk_in) disable iff (rst_in) cdb.valid |-> cdb.tag != '0
  ) else $error("cdb broadcast carries tag 0");

  a_full_not_idle: assert property (
    @(posedge clk_in) disable iff (rst_in) !(full && idle)
  ) else $error("full and idle are high together");

  a_no_cdb_after_reset: assert property (
    @(posedge clk_in) rst_in |=> !cdb.valid
  ) else $error("cdb.valid is high in the cycle after reset");

endmodule

bind tomasulo_core tomasulo_core_properties props (
  .clk_in(clk_in),
  .rst_in(rst_in),
  .cdb(cdb),
  .full(full),
  .idle(idle)
);

`default_nettype wire

/* bench/tomasulo_checker.sv */
`default_nettype none

module tomasulo_checker #(
  parameter int NUM_RS = 6
) (
  input wire clk_in,
  input wire rst_in,
  input wire inst_valid,
  input wire tomasulo_pkg::word_t inst,
  input wire full,
  input wire idle,
  input wire tomasulo_pkg::cdb_t cdb,
  input wire [NUM_RS-1:0] alloc,
  input wire exp_check,
  input wire tomasulo_pkg::word_t exp_value,
  input wire [7:0] test_num,
  input wire end_test,
  output tomasulo_pkg::reg_id_t dbg_reg_addr,
  input wire tomasulo_pkg::word_t dbg_reg_data,
  output logic check_done,
  output int error_count,
  output int check_count
);

  tomasulo_pkg::word_t model [0:31];
  tomasulo_pkg::word_t tag_value [0:15];
  int pending [0:15];
  int accepted;
  int broadcasts;
  int test_errors;
  logic reset_seen;

  // RV32I OP and OP-IMM encodings that the core supports
  function automatic logic inst_legal(tomasulo_pkg::word_t w);
    logic [6:0] f7;
    f7 = w[31:25];
    if (w[6:0] == 7'h33) begin
      return f7 == 7'h00 || (f7 == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5));
    end
    if (w[6:0] == 7'h13) begin
      if (w[14:12] == 3'd1) return f7 == 7'h00;
      if (w[14:12] == 3'd5) return f7 == 7'h00 || f7 == 7'h20;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic tomasulo_pkg::word_t model_result(tomasulo_pkg::word_t w,
      tomasulo_pkg::word_t a, tomasulo_pkg::word_t b);
    tomasulo_pkg::word_t rhs;
    logic alt;
    rhs = (w[6:0] == 7'h13) ? {{20{w[31]}}, w[31:20]} : b;
    alt = w[30];
    case (w[14:12])
      3'd0: return (w[6:0] == 7'h33 && alt) ? a - rhs : a + rhs;
      3'd1: return a << rhs[4:0];
      3'd2: return ($signed(a) < $signed(rhs)) ? 32'd1 : 32'd0;
      3'd3: return (a < rhs) ? 32'd1 : 32'd0;
      3'd4: return a ^ rhs;
      3'd5: begin
        if (alt) return $signed(a) >>> rhs[4:0];
        return a >> rhs[4:0];
      end
      3'd6: return a | rhs;
      default: return a & rhs;
    endcase
  endfunction

  initial begin
    for (int i = 0; i < 32; i++) model[i] = '0;
    for (int i = 0; i < 16; i++) pending[i] = 0;
    for (int i = 0; i < 16; i++) tag_value[i] = '0;
    accepted = 0;
    broadcasts = 0;
    test_errors = 0;
    reset_seen = 1'b0;
    dbg_reg_addr = '0;
    check_done = 1'b0;
    error_count = 0;
    check_count = 0;
  end

  // program-order model run as each strobe is taken
  always @(negedge clk_in) begin : watch_bus
    tomasulo_pkg::word_t res;
    if (rst_in) begin
      reset_seen = 1'b1;
    end else begin
      if (reset_seen && cdb.valid) begin
        $display("cdb.valid was high in the first cycle after reset");
        error_count++;
        test_errors++;
      end
      reset_seen = 1'b0;
      if (full && idle) begin
        $display("full and idle were high in the same cycle");
        error_count++;
        test_errors++;
      end
      if (cdb.valid) begin
        broadcasts++;
        if (pending[cdb.tag] == 0) begin
          $display("tag %0d was broadcast with no station load outstanding", cdb.tag);
          error_count++;
          test_errors++;
        end else begin
          pending[cdb.tag]--;
          check_count++;
          if (cdb.value !== tag_value[cdb.tag]) begin
            $display("** Error: test %0d cdb.value tag %0d expected 0x%08h actual 0x%08h",
                     test_num, cdb.tag, tag_value[cdb.tag], cdb.value);
            error_count++;
            test_errors++;
          end
        end
      end
      for (int i = 0; i < NUM_RS; i++) begin
        if (alloc[i]) pending[i+1]++;
      end
      if (inst_valid && full) begin
        $display("an instruction was strobed while full was high");
        error_count++;
        test_errors++;
      end else if (inst_valid && inst_legal(inst)) begin
        res = model_result(inst, model[inst[19:15]], model[inst[24:20]]);
        accepted++;
        if (inst[11:7] != 5'd0) model[inst[11:7]] = res;
        // result the loaded station must broadcast
        for (int i = 0; i < NUM_RS; i++) begin
          if (alloc[i]) tag_value[i+1] = exp_check ? exp_value : res;
        end
        check_count++;
        if (alloc == '0) begin
          $display("instruction %08h was accepted but loaded no station", inst);
          error_count++;
          test_errors++;
        end
        if (exp_check) begin
          check_count++;
          if (res !== exp_value) begin
            $display("** Error: test %0d pattern value x%0d expected 0x%08h model 0x%08h",
                     test_num, inst[11:7], exp_value, res);
            error_count++;
            test_errors++;
          end
        end
      end else if (inst_valid) begin
        check_count++;
        if (alloc != '0) begin
          $display("unsupported instruction %08h loaded a station", inst);
          error_count++;
          test_errors++;
        end
      end
    end
  end

  always @(negedge clk_in) begin : read_back
    if (end_test) begin
      for (int r = 1; r < 32; r++) begin
        @(posedge clk_in);
        dbg_reg_addr <= tomasulo_pkg::reg_id_t'(r);
        @(negedge clk_in);
        check_count++;
        if (dbg_reg_data !== model[r]) begin
          $display("** Error: test %0d dbg_reg_data x%0d expected 0x%08h actual 0x%08h",
                   test_num, r, model[r], dbg_reg_data);
          error_count++;
          test_errors++;
        end
      end
      check_count++;
      if (broadcasts != accepted) begin
        $display("** Error: test %0d cdb.valid count expected 0x%0h actual 0x%0h",
                 test_num, accepted, broadcasts);
        error_count++;
        test_errors++;
      end
      if (test_errors == 0) begin
        $display("test %0d: %0d instructions taken, registers and broadcasts match",
                 test_num, accepted);
      end else begin
        $display("test %0d: %0d mismatches", test_num, test_errors);
      end
      accepted = 0;
      broadcasts = 0;
      test_errors = 0;
      @(posedge clk_in);
      check_done <= 1'b1;
      @(posedge clk_in);
      check_done <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* bench/tomasulo_core_tb.sv */
`default_nettype none

module tomasulo_core_tb;

  localparam int NUM_RS = 6;
  localparam int RANDOM_COUNT = 200;
  localparam int MAX_RECORDS = 64;
  localparam logic [31:0] SEED = 32'h176baa88;

  logic clk_in;
  logic rst_in;
  logic inst_valid;
  tomasulo_pkg::rv_inst_u inst;
  logic full;
  logic idle;
  tomasulo_pkg::cdb_t cdb;
  tomasulo_pkg::reg_id_t dbg_reg_addr;
  tomasulo_pkg::word_t dbg_reg_data;

  logic exp_check;
  tomasulo_pkg::word_t exp_value;
  logic [7:0] test_num;
  logic end_test;
  logic check_done;
  int error_count;
  int check_count;

  // three words per record for test, instruction and expected result
  logic [31:0] patterns [0:3*MAX_RECORDS-1];
  int num_records;
  int timeout_cycles;
  logic limit_set;
  int tests_done;
  int bench_errors;
  logic [7:0] cur_test;
  logic [31:0] seed_draw;

  always #2 clk_in = ~clk_in;

  tomasulo_core #(
    .NUM_RS(NUM_RS)
  ) uut (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .inst_valid(inst_valid),
    .inst(inst),
    .full(full),
    .idle(idle),
    .cdb(cdb),
    .dbg_reg_addr(dbg_reg_addr),
    .dbg_reg_data(dbg_reg_data)
  );

  tomasulo_checker #(
    .NUM_RS(NUM_RS)
  ) checker_0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .inst_valid(inst_valid),
    .inst(inst),
    .full(full),
    .idle(idle),
    .cdb(cdb),
    .alloc(uut.alloc_onehot),
    .exp_check(exp_check),
    .exp_value(exp_value),
    .test_num(test_num),
    .end_test(end_test),
    .dbg_reg_addr(dbg_reg_addr),
    .dbg_reg_data(dbg_reg_data),
    .check_done(check_done),
    .error_count(error_count),
    .check_count(check_count)
  );

  function automatic tomasulo_pkg::word_t random_alu_inst();
    tomasulo_pkg::reg_id_t rd;
    tomasulo_pkg::reg_id_t rs1;
    tomasulo_pkg::reg_id_t rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    rd = tomasulo_pkg::reg_id_t'(1 + $urandom % 7);
    rs1 = tomasulo_pkg::reg_id_t'(1 + $urandom % 7);
    rs2 = tomasulo_pkg::reg_id_t'(1 + $urandom % 7);
    f3 = 3'($urandom % 8);
    f7 = tomasulo_pkg::F7_BASE;
    if ($urandom % 2 == 0) begin
      if ((f3 == tomasulo_pkg::F3_ADD || f3 == tomasulo_pkg::F3_SRL) && $urandom % 2 == 1) begin
        f7 = tomasulo_pkg::F7_ALT;
      end
      return {f7, rs2, rs1, f3, rd, tomasulo_pkg::OPC_OP};
    end
    imm = 12'($urandom % 4096);
    if (f3 == tomasulo_pkg::F3_SLL) imm[11:5] = tomasulo_pkg::F7_BASE;
    if (f3 == tomasulo_pkg::F3_SRL) begin
      imm[11:5] = ($urandom % 2 == 1) ? tomasulo_pkg::F7_ALT : tomasulo_pkg::F7_BASE;
    end
    return {imm, rs1, f3, rd, tomasulo_pkg::OPC_OP_IMM};
  endfunction

  // strobe only after a cycle with full low and no strobe
  task automatic send_inst(input tomasulo_pkg::word_t word, input logic check,
      input tomasulo_pkg::word_t expected);
    do @(negedge clk_in); while (full);
    @(posedge clk_in);
    inst_valid <= 1'b1;
    inst <= word;
    exp_check <= check;
    exp_value <= expected;
    @(posedge clk_in);
    inst_valid <= 1'b0;
    exp_check <= 1'b0;
  endtask

  task automatic start_test(input logic [7:0] num);
    @(posedge clk_in);
    test_num <= num;
  endtask

  task automatic finish_test();
    do @(negedge clk_in); while (!idle);
    @(posedge clk_in);
    end_test <= 1'b1;
    @(posedge clk_in);
    end_test <= 1'b0;
    do @(negedge clk_in); while (!check_done);
    tests_done++;
  endtask

  initial begin
    clk_in = 1'b0;
    rst_in = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    exp_check = 1'b0;
    exp_value = '0;
    test_num = '0;
    end_test = 1'b0;
    limit_set = 1'b0;
    tests_done = 0;
    bench_errors = 0;
    seed_draw = $urandom(SEED);
    $readmemh("bench/alu_patterns.txt", patterns);
    num_records = 0;
    while (num_records < MAX_RECORDS && !$isunknown(patterns[3*num_records])) begin
      num_records++;
    end
    if (num_records == 0) begin
      $display("no pattern records were read from bench/alu_patterns.txt");
      bench_errors++;
    end
    timeout_cycles = (num_records + RANDOM_COUNT) * (NUM_RS + 4) + 64;
    limit_set = 1'b1;
    repeat (16) @(posedge clk_in);
    rst_in <= 1'b0;
    cur_test = (num_records > 0) ? patterns[0][7:0] : 8'd0;
    start_test(cur_test);
    for (int i = 0; i < num_records; i++) begin
      if (patterns[3*i][7:0] != cur_test) begin
        finish_test();
        cur_test = patterns[3*i][7:0];
        start_test(cur_test);
      end
      send_inst(patterns[3*i+1], 1'b1, patterns[3*i+2]);
    end
    if (num_records > 0) finish_test();
    // random burst over x1 to x7
    start_test(cur_test + 8'd1);
    repeat (RANDOM_COUNT) send_inst(random_alu_inst(), 1'b0, '0);
    finish_test();
    $display("tests %0d, checks %0d, errors %0d", tests_done, check_count,
             error_count + bench_errors);
    if (error_count + bench_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_set);
    repeat (timeout_cycles) @(posedge clk_in);
    $display("timeout: the run did not end within %0d cycles", timeout_cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/alu_patterns.txt */
// columns: test number, instruction word, expected result of the instruction
// rejected strobes carry 00000000 as the expected result
01 00500093 00000005
01 FFD08113 00000002
01 002081B3 00000007
01 40118233 00000002
01 00321293 00000010
01 0032C333 00000017
01 FC000393 FFFFFFC0
01 4043D433 FFFFFFF0
01 0043D4B3 3FFFFFF0
01 0013A533 00000001
01 0013B5B3 00000000
01 00936633 3FFFFFF7
01 0F067693 000000F0
01 FFF0B713 00000001
01 4043D793 FFFFFFFC
02 00F788B3 FFFFFFF8
02 01188933 FFFFFFF0
02 12300913 00000123
03 06408013 00000069
03 00418033 00000009
03 001009B3 00000005
04 0000AA03 00000000
04 02208A33 00000000
04 40109A13 00000000
04 4020CA33 00000000
04 001A0A13 00000001

/* tomasulo_core.f */
rtl/tomasulo_pkg.sv
rtl/reg_status_file.sv
rtl/issue_unit.sv
rtl/rs_entry.sv
rtl/cdb_arbiter.sv
rtl/tomasulo_core.sv
bench/tomasulo_core_properties.sv
bench/tomasulo_checker.sv
bench/tomasulo_core_tb.sv
